//--- build.f
logic/rasterPkg.sv
logic/wbPkg.sv
logic/lineStepper.sv
logic/regInterface.sv
logic/pixelFrame.sv
logic/lineRasterTop.sv
tb/lineRaster_properties.sv
tb/lineRasterTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= lineRasterTb
FILELIST ?= build.f
OBJDIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)

//--- tb/lineRasterTb.sv
// Directed testbench for lineRasterTop at CoordBits 6, a 64 by 64 frame.
// Frame checks read all 128 row words and compare them with a Bresenham model.
// Assumes the host drops stb one cycle after it sees ack.
`timescale 1ns/1ps
`default_nettype none

module lineRasterTb;
	import rasterPkg::*;
	import wbPkg::*;

	localparam int CoordBits = 6;
	localparam int GridSize = 2 ** CoordBits;
	localparam int WordsPerRow = GridSize / 32;
	localparam int NumWords = GridSize * WordsPerRow;
	localparam int ClkPeriod = 40;
	// Lines with polling, then full frame reads and the remaining transfers
	localparam int NumLines = 40;
	localparam int NumFrameChecks = 36;
	localparam int CyclesPerTransfer = 4;
	localparam int RunCycles = NumLines * (GridSize + 3 * CyclesPerTransfer)
		+ (NumFrameChecks * NumWords + 200) * CyclesPerTransfer;
	localparam longint TimeoutNs = 2 * RunCycles * ClkPeriod;

	logic clk;
	logic n_rst;
	wbReq_t wbReq;
	wbRsp_t wbRsp;
	logic [GridSize-1:0] refRows [GridSize];
	integer seed = 32'h87ee;
	int cycleCount = 0;
	int lastAckCycle;
	int errorCount = 0;

	lineRasterTop #(.CoordBits(CoordBits)) dut (
		.clk(clk),
		.n_rst(n_rst),
		.wbReq(wbReq),
		.wbRsp(wbRsp)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic failRun(input string msg);
		errorCount++;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	// Returns 1 ns after the edge that registered ack
	task automatic waitAck();
		do begin
			@(posedge clk);
			#1;
		end while (!wbRsp.ack);
		lastAckCycle = cycleCount;
	endtask

	task automatic wbWrite(input logic [WbAddrBits-1:0] adr, input logic [WbDataBits-1:0] dat);
		@(posedge clk);
		#1;
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		waitAck();
		@(posedge clk);
		#1;
		wbReq = '0;
	endtask

	task automatic wbRead(input logic [WbAddrBits-1:0] adr, output logic [WbDataBits-1:0] dat);
		@(posedge clk);
		#1;
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
		waitAck();
		dat = wbRsp.dat;
		@(posedge clk);
		#1;
		wbReq = '0;
	endtask

	function automatic int absDiff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic int randCoord();
		return $random(seed) & (GridSize - 1);
	endfunction

	task automatic clearModel();
		foreach (refRows[y]) refRows[y] = '0;
	endtask

	// Reference Bresenham walk, both steps decided from the same doubled error
	task automatic modelLine(input int x0, input int y0, input int x1, input int y1);
		int dx, dy, err, e2, x, y;
		bit done;
		dx = absDiff(x0, x1);
		dy = absDiff(y0, y1);
		err = dx - dy;
		x = x0;
		y = y0;
		done = 1'b0;
		while (!done) begin
			refRows[y][x] = 1'b1;
			if (x == x1 && y == y1) begin
				done = 1'b1;
			end else begin
				e2 = 2 * err;
				if (e2 > -dy) begin
					err -= dy;
					x += (x1 < x0) ? -1 : 1;
				end
				if (e2 < dx) begin
					err += dx;
					y += (y1 < y0) ? -1 : 1;
				end
			end
		end
	endtask

	task automatic drawLine(input int x0, input int y0, input int x1, input int y1);
		wbWrite(AdrLine, {8'(x0), 8'(y0), 8'(x1), 8'(y1)});
		modelLine(x0, y0, x1, y1);
	endtask

	task automatic clearFrame();
		wbWrite(AdrClear, '0);
		clearModel();
	endtask

	task automatic waitIdle();
		logic [WbDataBits-1:0] st;
		do begin
			wbRead(AdrStatus, st);
		end while (st[0]);
		assert (st == '0)
			else failRun($sformatf("ERR %0t: status expected 0 read %h", $time, st));
	endtask

	task automatic checkFrame();
		logic [WbDataBits-1:0] got;
		logic [WbDataBits-1:0] exp;
		for (int w = 0; w < NumWords; w++) begin
			wbRead(WbAddrBits'(AdrFrameBase + w), got);
			exp = refRows[w / WordsPerRow][(w % WordsPerRow) * 32 +: 32];
			assert (got === exp)
				else failRun($sformatf("ERR %0t: frame word %0d expected %h read %h",
					$time, w, exp, got));
		end
	endtask

	// A held-off write is acked only after the pixels of the running line
	task automatic checkAckGap(input int firstAck, input int pixels, input string what);
		assert (lastAckCycle - firstAck > pixels)
			else failRun($sformatf("%s was accepted while a line was still drawing", what));
	endtask

	task automatic testReset();
		waitIdle();
		checkFrame();
	endtask

	task automatic testBasicLines();
		clearFrame();
		drawLine(5, 10, 50, 10);
		drawLine(20, 3, 20, 60);
		drawLine(0, 0, 63, 63);
		drawLine(63, 0, 0, 63);
		waitIdle();
		checkFrame();
		clearFrame();
		drawLine(33, 17, 33, 17);
		waitIdle();
		checkFrame();
	endtask

	// Bits of i pick the octant: x direction, y direction, steepness
	task automatic testRandomLines();
		int x0, y0, x1, y1;
		for (int i = 0; i < 30; i++) begin
			x0 = randCoord();
			y0 = randCoord();
			x1 = randCoord();
			y1 = randCoord();
			if (((i >> 2) & 1) != (absDiff(y0, y1) > absDiff(x0, x1)))
				{x0, y0, x1, y1} = {y0, x0, y1, x1};
			if ((i & 1) != (x1 < x0))
				{x0, x1} = {x1, x0};
			if (((i >> 1) & 1) != (y1 < y0))
				{y0, y1} = {y1, y0};
			clearFrame();
			drawLine(x0, y0, x1, y1);
			waitIdle();
			checkFrame();
		end
	endtask

	task automatic testBackPressure();
		int firstAck;
		clearFrame();
		// 64 pixels along x
		drawLine(0, 5, 63, 40);
		firstAck = lastAckCycle;
		drawLine(10, 60, 50, 2);
		checkAckGap(firstAck, 64, "Second line command");
		waitIdle();
		checkFrame();
	endtask

	task automatic testClearWhileDrawing();
		int firstAck;
		drawLine(63, 63, 0, 20);
		firstAck = lastAckCycle;
		clearFrame();
		checkAckGap(firstAck, 64, "Clear command");
		waitIdle();
		checkFrame();
	endtask

	task automatic testIgnoredAccess();
		logic [WbDataBits-1:0] got;
		logic [WbAddrBits-1:0] unused [4] = '{10'd3, 10'd511, 10'd640, 10'd1023};
		drawLine(3, 7, 40, 30);
		waitIdle();
		wbWrite(AdrStatus, '1);
		waitIdle();
		checkFrame();
		foreach (unused[i]) begin
			wbRead(unused[i], got);
			assert (got == '0)
				else failRun($sformatf("ERR %0t: address %0d expected 0 read %h",
					$time, unused[i], got));
		end
	endtask

	initial begin
		clk = 1'b0;
		n_rst = 1'b0;
		wbReq = '0;
		clearModel();
		repeat (2) @(posedge clk);
		#1;
		n_rst = 1'b1;
		testReset();
		testBasicLines();
		testRandomLines();
		testBackPressure();
		testClearWhileDrawing();
		testIgnoredAccess();
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(TimeoutNs);
		failRun("Timeout: the tests did not finish in the expected time");
	end

endmodule

`default_nettype wire

//--- tb/lineRaster_properties.sv
// Bus handshake and stepper interlock checks, bound into every lineRasterTop.
// Inactive while n_rst is low.
`timescale 1ns/1ps
`default_nettype none

module lineRaster_properties (
	input wire logic clk,
	input wire logic n_rst,
	input wire wbPkg::wbReq_t wbReq,
	input wire wbPkg::wbRsp_t wbRsp,
	input wire logic busy,
	input wire logic start,
	input wire rasterPkg::pixelWr_t pixel
);

	ackInCycle: assert property (@(posedge clk) disable iff (!n_rst)
		wbRsp.ack |-> (wbReq.cyc && wbReq.stb))
		else $error("ack high without cyc and stb");

	ackSingle: assert property (@(posedge clk) disable iff (!n_rst)
		wbRsp.ack |=> !wbRsp.ack)
		else $error("ack held for two cycles");

	// A pixel either continues a busy run or directly follows a start
	pixelWhileBusy: assert property (@(posedge clk) disable iff (!n_rst)
		pixel.valid |-> ($past(busy) || $past(start)))
		else $error("pixel write outside a line");

	startWhileIdle: assert property (@(posedge clk) disable iff (!n_rst)
		start |-> !busy)
		else $error("start while the stepper is busy");

endmodule

bind lineRasterTop lineRaster_properties props (
	.clk(clk),
	.n_rst(n_rst),
	.wbReq(wbReq),
	.wbRsp(wbRsp),
	.busy(busy),
	.start(start),
	.pixel(pixel)
);

`default_nettype wire

//--- logic/lineRasterTop.sv
// Line rasterizer: Wishbone slave, Bresenham stepper and frame memory.
// CoordBits sets the grid size, 5 to 8; the frame readback window holds 512
// words, so an 8-bit grid can only be partly read back over the bus.
`timescale 1ns/1ps
`default_nettype none

module lineRasterTop #(
	parameter int CoordBits = 6,
	localparam int WordsPerRow = ((2 ** CoordBits) >= 32) ? (2 ** CoordBits) / 32 : 1,
	localparam int WordIdxBits = $clog2((2 ** CoordBits) * WordsPerRow)
) (
	input wire logic clk,
	input wire logic n_rst,
	input wire wbPkg::wbReq_t wbReq,
	output wbPkg::wbRsp_t wbRsp
);
	import rasterPkg::*;
	import wbPkg::*;

	lineCmd_t cmd;
	pixelWr_t pixel;
	logic start;
	logic busy;
	logic clear;
	logic [WordIdxBits-1:0] rowWord;
	logic [WbDataBits-1:0] rdData;

	regInterface #(.CoordBits(CoordBits)) regs (
		.clk(clk),
		.n_rst(n_rst),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.busy(busy),
		.cmd(cmd),
		.start(start),
		.clear(clear),
		.rowWord(rowWord),
		.rdData(rdData)
	);

	lineStepper #(.CoordBits(CoordBits)) stepper (
		.clk(clk),
		.n_rst(n_rst),
		.cmd(cmd),
		.start(start),
		.busy(busy),
		.pixel(pixel)
	);

	pixelFrame #(.CoordBits(CoordBits)) frame (
		.clk(clk),
		.n_rst(n_rst),
		.pixel(pixel),
		.clear(clear),
		.rowWord(rowWord),
		.rdData(rdData)
	);

endmodule

`default_nettype wire

//--- logic/pixelFrame.sv
// One-bit frame of 2**CoordBits square, held in flops so a clear takes one cycle.
// Pixel (x, y) is bit y * width + x; row words are 32 bits, lowest word first.
// Clear wins over a pixel set in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module pixelFrame #(
	parameter int CoordBits = 6,
	localparam int WordsPerRow = ((2 ** CoordBits) >= 32) ? (2 ** CoordBits) / 32 : 1,
	localparam int NumWords = (2 ** CoordBits) * WordsPerRow,
	localparam int WordIdxBits = $clog2(NumWords)
) (
	input wire logic clk,
	input wire logic n_rst,
	input wire rasterPkg::pixelWr_t pixel,
	input wire logic clear,
	input wire logic [WordIdxBits-1:0] rowWord,
	output logic [wbPkg::WbDataBits-1:0] rdData
);

	localparam int NumBits = NumWords * 32;

	logic [NumBits-1:0] frame;
	logic [2*CoordBits-1:0] bitIdx;

	// Row-major bit address
	assign bitIdx = {pixel.pt.y[CoordBits-1:0], pixel.pt.x[CoordBits-1:0]};

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			frame <= '0;
		end else if (clear) begin
			frame <= '0;
		end else if (pixel.valid) begin
			frame[bitIdx] <= 1'b1;
		end
	end

	// Rows are whole words, so row * WordsPerRow + word lands on a 32-bit slice
	assign rdData = frame[rowWord * 32 +: 32];

endmodule

`default_nettype wire

//--- logic/regInterface.sv
// Wishbone classic slave for line commands, status, clear and frame readback.
// Line and clear writes are held off with no ack while the stepper is busy.
// Every ack is registered and lasts one cycle; reads return data with the ack.
// Only frame words below NumWords and inside the 10-bit address space answer.
`timescale 1ns/1ps
`default_nettype none

module regInterface #(
	parameter int CoordBits = 6,
	localparam int WordsPerRow = ((2 ** CoordBits) >= 32) ? (2 ** CoordBits) / 32 : 1,
	localparam int NumWords = (2 ** CoordBits) * WordsPerRow,
	localparam int WordIdxBits = $clog2(NumWords)
) (
	input wire logic clk,
	input wire logic n_rst,
	input wire wbPkg::wbReq_t wbReq,
	output wbPkg::wbRsp_t wbRsp,
	input wire logic busy,
	output rasterPkg::lineCmd_t cmd,
	output logic start,
	output logic clear,
	output logic [WordIdxBits-1:0] rowWord,
	input wire logic [wbPkg::WbDataBits-1:0] rdData
);
	import wbPkg::*;
	import rasterPkg::*;

	localparam coord_t CoordMask = coord_t'((1 << CoordBits) - 1);

	logic ackQ;
	logic [WbDataBits-1:0] rdQ;
	logic reqSeen, ackNext, lineOrClear;
	logic isLine, isStatus, isClear, isFrame;
	logic [WbAddrBits-1:0] frameOff;
	logic [WbDataBits-1:0] rdValue;
	lineCmd_t cmdIn;

	// New request only when the previous ack has gone
	assign reqSeen = wbReq.cyc && wbReq.stb && !ackQ;

	assign isLine = wbReq.adr == AdrLine;
	assign isStatus = wbReq.adr == AdrStatus;
	assign isClear = wbReq.adr == AdrClear;
	assign frameOff = wbReq.adr - AdrFrameBase;
	assign isFrame = (wbReq.adr >= AdrFrameBase) && (frameOff < NumWords);

	// Back-pressure on line and clear writes
	assign lineOrClear = wbReq.we && (isLine || isClear);
	assign ackNext = reqSeen && !(lineOrClear && busy);

	// Out-of-grid coordinate bits are dropped here
	assign cmdIn = lineCmd_t'(wbReq.dat & {4{CoordMask}});

	assign rowWord = WordIdxBits'(frameOff);

	always_comb begin
		rdValue = '0;
		if (isStatus) begin
			rdValue = {{(WbDataBits - 1){1'b0}}, busy};
		end else if (isLine) begin
			rdValue = cmd;
		end else if (isFrame) begin
			rdValue = rdData;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			ackQ <= 1'b0;
			start <= 1'b0;
			clear <= 1'b0;
		end else begin
			ackQ <= ackNext;
			// Pulses line up with the ack
			start <= ackNext && wbReq.we && isLine;
			clear <= ackNext && wbReq.we && isClear;
		end
	end

	always_ff @(posedge clk) begin
		if (ackNext && !wbReq.we) begin
			rdQ <= rdValue;
		end
		if (ackNext && wbReq.we && isLine) begin
			cmd <= cmdIn;
		end
	end

	assign wbRsp = '{ack: ackQ, dat: rdQ};

endmodule

`default_nettype wire

//--- logic/lineStepper.sv
// Bresenham line engine, one pixel per clock in any octant.
// start must only arrive while idle; the command is sampled on that cycle.
// Coordinates above CoordBits are ignored, so lines wrap with the grid.
`timescale 1ns/1ps
`default_nettype none

module lineStepper #(
	parameter int CoordBits = 6
) (
	input wire logic clk,
	input wire logic n_rst,
	input wire rasterPkg::lineCmd_t cmd,
	input wire logic start,
	output logic busy,
	output rasterPkg::pixelWr_t pixel
);
	import rasterPkg::*;

	// Room for twice the largest difference plus sign
	localparam int ErrBits = CoordBits + 3;

	typedef enum logic {
		Idle,
		Draw
	} state_t;

	state_t state;
	state_t stateNext;

	logic [CoordBits-1:0] x0, y0, x1, y1;
	logic [CoordBits-1:0] curX, curY;
	logic [CoordBits-1:0] endX, endY;
	logic xDec, yDec;
	logic signed [ErrBits-1:0] dx, dy, err;
	logic signed [ErrBits-1:0] dxLoad, dyLoad, e2;
	logic stepX, stepY, atEnd;

	assign x0 = cmd.p0.x[CoordBits-1:0];
	assign y0 = cmd.p0.y[CoordBits-1:0];
	assign x1 = cmd.p1.x[CoordBits-1:0];
	assign y1 = cmd.p1.y[CoordBits-1:0];

	// Absolute differences of the new command
	assign dxLoad = (x1 >= x0) ? $signed(ErrBits'(x1 - x0)) : $signed(ErrBits'(x0 - x1));
	assign dyLoad = (y1 >= y0) ? $signed(ErrBits'(y1 - y0)) : $signed(ErrBits'(y0 - y1));

	assign e2 = err <<< 1;
	assign stepX = e2 > -dy;
	assign stepY = e2 < dx;
	assign atEnd = (curX == endX) && (curY == endY);

	always_comb begin
		stateNext = state;
		case (state)
			Idle: if (start) stateNext = Draw;
			Draw: if (atEnd) stateNext = Idle;
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= Idle;
		end else begin
			state <= stateNext;
		end
	end

	always_ff @(posedge clk) begin
		if (state == Idle && start) begin
			curX <= x0;
			curY <= y0;
			endX <= x1;
			endY <= y1;
			dx <= dxLoad;
			dy <= dyLoad;
			err <= dxLoad - dyLoad;
			xDec <= x1 < x0;
			yDec <= y1 < y0;
		end else if (state == Draw && !atEnd) begin
			// Diagonal steps take both branches
			if (stepX) begin
				curX <= xDec ? curX - 1'b1 : curX + 1'b1;
			end
			if (stepY) begin
				curY <= yDec ? curY - 1'b1 : curY + 1'b1;
			end
			err <= err - (stepX ? dy : '0) + (stepY ? dx : '0);
		end
	end

	assign busy = state == Draw;

	// Current point is written in every draw cycle, p0 first
	assign pixel = '{valid: busy, pt: '{x: coord_t'(curX), y: coord_t'(curY)}};

endmodule

`default_nettype wire

//--- logic/wbPkg.sv
// Wishbone classic request and response bundles, plus the register map.
// Addresses are word addresses; there are no byte selects.
// Frame words start at AdrFrameBase, so at most 512 frame words are reachable.
`default_nettype none

package wbPkg;

	localparam int WbDataBits = 32;
	localparam int WbAddrBits = 10;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WbAddrBits-1:0] adr;
		logic [WbDataBits-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [WbDataBits-1:0] dat;
	} wbRsp_t;

	// Write a line command here, drawing starts on the ack
	localparam logic [WbAddrBits-1:0] AdrLine = WbAddrBits'(0);
	// Read only, bit 0 is busy
	localparam logic [WbAddrBits-1:0] AdrStatus = WbAddrBits'(1);
	// Any write clears the whole frame
	localparam logic [WbAddrBits-1:0] AdrClear = WbAddrBits'(2);
	// Row words, lowest word of row 0 first
	localparam logic [WbAddrBits-1:0] AdrFrameBase = WbAddrBits'(512);

endpackage

`default_nettype wire

//--- logic/rasterPkg.sv
// Geometry types shared by the bus slave, the line stepper and the frame memory.
// Structs are sized for the widest grid; modules use only the low CoordBits bits.
// A pixel x maps to a column, y to a row; origin at row 0, bit 0.
`default_nettype none

package rasterPkg;

	// Widest supported grid is 256 by 256
	localparam int MaxCoordBits = 8;

	typedef logic [MaxCoordBits-1:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	// Bus word layout, high to low: p0.x, p0.y, p1.x, p1.y
	typedef struct packed {
		point_t p0;
		point_t p1;
	} lineCmd_t;

	// One pixel set request per clock
	typedef struct packed {
		logic valid;
		point_t pt;
	} pixelWr_t;

endpackage

`default_nettype wire
